//--- hw/calc_pkg.sv
package calc_pkg;

    localparam int DATA_W           = 16;  // operand and result width
    localparam int BCD_DIGITS       = 5;   // enough for 32768
    localparam int SHIFT_CNT_W      = 4;   // counts DATA_W shift steps

    localparam int DEBOUNCE_CYCLES  = 10;  // low cycles that confirm a key
    localparam int DEBOUNCE_W       = 4;

    localparam int MAX_ENTRY_DIGITS = 4;   // 9999 fits a signed 16 bit word
    localparam int ENTRY_CNT_W      = 3;

    typedef enum logic [2:0] {
        OP_NONE = 3'd0,
        OP_NEG  = 3'd1,  // sign change of the entry
        OP_ADD  = 3'd2,
        OP_SUB  = 3'd3,
        OP_MUL  = 3'd4
    } op_t;

    // keypad index is row*4 + col
    localparam logic [3:0] KEY_ADD    = 4'd3;   // key A
    localparam logic [3:0] KEY_SUB    = 4'd7;   // key B
    localparam logic [3:0] KEY_MUL    = 4'd11;  // key C
    localparam logic [3:0] KEY_EQUAL  = 4'd12;  // '*'
    localparam logic [3:0] KEY_IGNORE = 4'd14;  // '#'
    localparam logic [3:0] KEY_NEG    = 4'd15;  // key D

    // digit carried on keypad_input when the key has none
    // keeps digit 0 apart from the '#' key
    localparam logic [3:0] NO_DIGIT   = 4'hF;

    // digit value per key index
    localparam logic [3:0] KEY_DIGIT [16] = '{
        4'd1, 4'd2, 4'd3, NO_DIGIT,
        4'd4, 4'd5, 4'd6, NO_DIGIT,
        4'd7, 4'd8, 4'd9, NO_DIGIT,
        NO_DIGIT, 4'd0, NO_DIGIT, NO_DIGIT
    };

endpackage

//--- hw/keypad_scanner.sv
module keypad_scanner (
    input  logic            clk,
    input  logic            nRST,
    input  logic [3:0]      RowIn,           // active low, pulled up
    output logic [3:0]      ColOut,          // one column driven low
    output logic            read_input,      // key waiting for the controller
    input  logic            key_read,        // one cycle accept pulse
    output logic [3:0]      keypad_input,    // digit or NO_DIGIT
    output calc_pkg::op_t   operator_input,
    output logic            equal_input
);

    import calc_pkg::*;

    typedef enum logic [2:0] {
        IDLE,
        SCAN_COL,
        WAIT_STABLE,
        CONFIRM,
        WAIT_RELEASE
    } state_t;

    state_t                 state, next_state;
    logic [1:0]             col_index;       // column being driven
    logic [DEBOUNCE_W-1:0]  debounce_cnt;    // consecutive low cycles
    logic [3:0]             key_code;        // latched key index
    logic                   key_valid;       // some row low
    logic                   debounce_done;

    // lowest low row wins when several are down
    function automatic logic [3:0] encode_key(input logic [3:0] row, input logic [1:0] col);
        logic [1:0] r_sel;
        r_sel = 2'd0;
        for (int r = 3; r >= 0; r--) begin
            if (!row[r]) r_sel = 2'(r);
        end
        return {r_sel, col};
    endfunction

    assign key_valid     = ~&RowIn;
    assign debounce_done = (debounce_cnt == DEBOUNCE_W'(DEBOUNCE_CYCLES - 1));

    always_comb begin
        ColOut            = 4'b1111;
        ColOut[col_index] = 1'b0;            // walking zero
    end

    always_comb begin
        next_state = state;
        case (state)
            IDLE:         next_state = SCAN_COL;
            SCAN_COL:     next_state = key_valid ? WAIT_STABLE : SCAN_COL;
            WAIT_STABLE: begin
                if (!key_valid) next_state = SCAN_COL;       // bounce, start over
                else if (debounce_done) next_state = CONFIRM;
            end
            CONFIRM:      next_state = key_read ? WAIT_RELEASE : CONFIRM;
            WAIT_RELEASE: next_state = key_valid ? WAIT_RELEASE : IDLE;
            default:      next_state = IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge nRST) begin
        if (!nRST) begin
            state        <= IDLE;
            col_index    <= 2'd0;
            debounce_cnt <= '0;
            read_input   <= 1'b0;
            key_code     <= KEY_IGNORE;
        end else begin
            state <= next_state;
            case (state)
                SCAN_COL: begin
                    if (key_valid) debounce_cnt <= DEBOUNCE_W'(1);  // first low cycle counts
                    else col_index <= col_index + 2'd1;             // wraps 3 to 0
                end
                WAIT_STABLE: begin
                    if (!key_valid) begin
                        debounce_cnt <= '0;
                    end else if (debounce_done) begin
                        key_code   <= encode_key(RowIn, col_index);
                        read_input <= 1'b1;
                    end else begin
                        debounce_cnt <= debounce_cnt + DEBOUNCE_W'(1);
                    end
                end
                WAIT_RELEASE: begin
                    if (!key_valid) read_input <= 1'b0;   // all rows back high
                end
                default: ;
            endcase
        end
    end

    // key index to digit, operator or equal
    always_comb begin
        keypad_input   = KEY_DIGIT[key_code];
        operator_input = OP_NONE;
        equal_input    = 1'b0;
        case (key_code)
            KEY_ADD:    operator_input = OP_ADD;
            KEY_SUB:    operator_input = OP_SUB;
            KEY_MUL:    operator_input = OP_MUL;
            KEY_NEG:    operator_input = OP_NEG;
            KEY_EQUAL:  equal_input    = 1'b1;
            KEY_IGNORE: ;                          // '#' has no function
            default:    ;                          // digit keys
        endcase
    end

endmodule

//--- hw/calc_controller.sv
module calc_controller (
    input  logic                                 clk,
    input  logic                                 nRST,
    input  logic                                 read_input,
    input  logic [3:0]                           keypad_input,
    input  calc_pkg::op_t                        operator_input,
    input  logic                                 equal_input,
    output logic                                 key_read,
    output logic                                 calc_start,
    output logic signed [calc_pkg::DATA_W-1:0]   operand_a,
    output logic signed [calc_pkg::DATA_W-1:0]   operand_b,
    output calc_pkg::op_t                        calc_op,
    input  logic                                 arith_valid,
    input  logic signed [calc_pkg::DATA_W-1:0]   arith_result,
    input  logic                                 conv_busy
);

    import calc_pkg::*;

    logic signed [DATA_W-1:0]  entry;          // operand being typed
    logic signed [DATA_W-1:0]  acc;            // first operand or last result
    op_t                       pending_op;
    logic [ENTRY_CNT_W-1:0]    digit_cnt;      // digits in the entry
    logic                      key_done;       // key taken, wait for read_input low
    logic                      calc_pending;   // calc issued, result not back
    logic                      accept;
    logic                      is_digit;
    logic                      room;           // entry takes another digit
    logic signed [DATA_W-1:0]  entry_shifted;  // entry*10 + digit

    // hold the key while a result is still in flight
    assign accept   = read_input && !key_done && !calc_pending && !conv_busy;
    assign is_digit = (keypad_input != NO_DIGIT);
    assign room     = (digit_cnt < ENTRY_CNT_W'(MAX_ENTRY_DIGITS));

    always_comb begin
        entry_shifted = (entry <<< 3) + (entry <<< 1);   // times ten
        entry_shifted = entry_shifted + $signed({{(DATA_W-4){1'b0}}, keypad_input});
    end

    always_ff @(posedge clk or negedge nRST) begin
        if (!nRST) begin
            key_read     <= 1'b0;
            calc_start   <= 1'b0;
            key_done     <= 1'b0;
            calc_pending <= 1'b0;
            entry        <= '0;
            acc          <= '0;
            pending_op   <= OP_ADD;
            digit_cnt    <= '0;
        end else begin
            key_read   <= accept;
            calc_start <= accept && equal_input;

            if (accept) key_done <= 1'b1;
            else if (!read_input) key_done <= 1'b0;   // scanner saw the release

            if (accept && equal_input) calc_pending <= 1'b1;
            else if (arith_valid) calc_pending <= 1'b0;

            if (arith_valid) begin
                acc <= arith_result;                    // chaining
            end else if (accept) begin
                if (equal_input) begin
                    entry      <= '0;
                    digit_cnt  <= '0;
                    pending_op <= OP_ADD;               // next number adds to result
                end else if (operator_input == OP_NEG) begin
                    entry <= -entry;
                end else if (operator_input != OP_NONE) begin
                    if (digit_cnt != '0) acc <= entry;  // no digits keeps the result
                    pending_op <= operator_input;
                    entry      <= '0;
                    digit_cnt  <= '0;
                end else if (is_digit && room) begin
                    entry     <= entry_shifted;
                    digit_cnt <= digit_cnt + ENTRY_CNT_W'(1);
                end
                // '#' and excess digits fall through and are only acknowledged
            end
        end
    end

    // operands travel with calc_start
    always_ff @(posedge clk) begin
        if (accept && equal_input) begin
            operand_a <= acc;
            operand_b <= entry;
            calc_op   <= pending_op;
        end
    end

endmodule

//--- hw/arith_unit.sv
module arith_unit (
    input  logic                                 clk,
    input  logic                                 nRST,
    input  logic                                 calc_start,
    input  logic signed [calc_pkg::DATA_W-1:0]   operand_a,
    input  logic signed [calc_pkg::DATA_W-1:0]   operand_b,
    input  calc_pkg::op_t                        calc_op,
    output logic                                 arith_valid,
    output logic signed [calc_pkg::DATA_W-1:0]   arith_result,
    output logic                                 arith_ovf
);

    import calc_pkg::*;

    logic signed [DATA_W:0]      sum_ext;    // one guard bit
    logic signed [DATA_W:0]      diff_ext;
    logic signed [2*DATA_W-1:0]  prod;       // full product
    logic signed [DATA_W-1:0]    res_next;
    logic                        ovf_next;

    always_comb begin
        sum_ext  = {operand_a[DATA_W-1], operand_a} + {operand_b[DATA_W-1], operand_b};
        diff_ext = {operand_a[DATA_W-1], operand_a} - {operand_b[DATA_W-1], operand_b};
        prod     = operand_a * operand_b;
        case (calc_op)
            OP_ADD: begin
                res_next = sum_ext[DATA_W-1:0];                      // wraps
                ovf_next = sum_ext[DATA_W] ^ sum_ext[DATA_W-1];
            end
            OP_SUB: begin
                res_next = diff_ext[DATA_W-1:0];
                ovf_next = diff_ext[DATA_W] ^ diff_ext[DATA_W-1];
            end
            OP_MUL: begin
                res_next = prod[DATA_W-1:0];                         // low half only
                ovf_next = (prod[2*DATA_W-1:DATA_W-1] != {(DATA_W+1){prod[DATA_W-1]}});
            end
            default: begin
                res_next = operand_b;    // no operator pending
                ovf_next = 1'b0;
            end
        endcase
    end

    always_ff @(posedge clk or negedge nRST) begin
        if (!nRST) arith_valid <= 1'b0;
        else arith_valid <= calc_start;          // fixed one cycle latency
    end

    always_ff @(posedge clk) begin
        if (calc_start) begin
            arith_result <= res_next;
            arith_ovf    <= ovf_next;
        end
    end

endmodule

//--- hw/bin_to_bcd.sv
module bin_to_bcd (
    input  logic                                    clk,
    input  logic                                    nRST,
    input  logic                                    arith_valid,
    input  logic signed [calc_pkg::DATA_W-1:0]      arith_result,
    input  logic                                    arith_ovf,
    output logic                                    conv_busy,
    output logic                                    result_valid,
    output logic                                    result_neg,
    output logic [4*calc_pkg::BCD_DIGITS-1:0]       result_bcd,
    output logic                                    result_ovf
);

    import calc_pkg::*;

    logic [DATA_W-1:0]        mag_q;       // magnitude being shifted out
    logic [4*BCD_DIGITS-1:0]  bcd_q;       // digits being built
    logic                     neg_q;
    logic                     ovf_q;
    logic [SHIFT_CNT_W-1:0]   shift_cnt;
    logic [DATA_W-1:0]        mag_next;
    logic [4*BCD_DIGITS-1:0]  bcd_next;
    logic                     last_shift;

    // add 3 to every digit of 5 or more
    function automatic logic [4*BCD_DIGITS-1:0] add3(input logic [4*BCD_DIGITS-1:0] bcd);
        logic [4*BCD_DIGITS-1:0] res;
        res = bcd;
        for (int i = 0; i < BCD_DIGITS; i++) begin
            if (bcd[4*i +: 4] >= 4'd5) res[4*i +: 4] = bcd[4*i +: 4] + 4'd3;
        end
        return res;
    endfunction

    assign {bcd_next, mag_next} = {add3(bcd_q), mag_q} << 1;     // one double dabble step
    assign last_shift           = (shift_cnt == SHIFT_CNT_W'(DATA_W - 1));

    always_ff @(posedge clk or negedge nRST) begin
        if (!nRST) begin
            conv_busy    <= 1'b0;
            result_valid <= 1'b0;
            shift_cnt    <= '0;
        end else begin
            result_valid <= conv_busy && last_shift;
            if (arith_valid) begin
                conv_busy <= 1'b1;                      // load cycle
                shift_cnt <= '0;
            end else if (conv_busy) begin
                shift_cnt <= shift_cnt + SHIFT_CNT_W'(1);
                if (last_shift) conv_busy <= 1'b0;      // 16th shift done
            end
        end
    end

    always_ff @(posedge clk) begin
        if (arith_valid) begin
            neg_q <= arith_result[DATA_W-1];
            mag_q <= arith_result[DATA_W-1] ? DATA_W'(-arith_result) : arith_result;
            ovf_q <= arith_ovf;
            bcd_q <= '0;
        end else if (conv_busy) begin
            mag_q <= mag_next;
            bcd_q <= bcd_next;
        end
    end

    // outputs hold until the next conversion ends
    always_ff @(posedge clk) begin
        if (conv_busy && last_shift) begin
            result_bcd <= bcd_next;
            result_neg <= neg_q;
            result_ovf <= ovf_q;
        end
    end

endmodule

//--- hw/calc_top.sv
module calc_top (
    input  logic                                clk,
    input  logic                                nRST,
    input  logic [3:0]                          RowIn,
    output logic [3:0]                          ColOut,
    output logic                                result_valid,
    output logic                                result_neg,
    output logic [4*calc_pkg::BCD_DIGITS-1:0]   result_bcd,
    output logic                                result_ovf
);

    import calc_pkg::*;

    logic                      read_input;     // scanner to controller
    logic                      key_read;
    logic [3:0]                keypad_input;
    op_t                       operator_input;
    logic                      equal_input;
    logic                      calc_start;     // controller to arith
    logic signed [DATA_W-1:0]  operand_a;
    logic signed [DATA_W-1:0]  operand_b;
    op_t                       calc_op;
    logic                      arith_valid;    // arith to controller and bcd
    logic signed [DATA_W-1:0]  arith_result;
    logic                      arith_ovf;
    logic                      conv_busy;      // back-pressure to controller

    keypad_scanner i_keypad_scanner (
        .clk, .nRST, .RowIn, .ColOut, .read_input, .key_read,
        .keypad_input, .operator_input, .equal_input
    );

    calc_controller i_calc_controller (
        .clk, .nRST, .read_input, .keypad_input, .operator_input, .equal_input,
        .key_read, .calc_start, .operand_a, .operand_b, .calc_op,
        .arith_valid, .arith_result, .conv_busy
    );

    arith_unit i_arith_unit (
        .clk, .nRST, .calc_start, .operand_a, .operand_b, .calc_op,
        .arith_valid, .arith_result, .arith_ovf
    );

    bin_to_bcd i_bin_to_bcd (
        .clk, .nRST, .arith_valid, .arith_result, .arith_ovf,
        .conv_busy, .result_valid, .result_neg, .result_bcd, .result_ovf
    );

endmodule

//--- test/calc_checker.sv
module calc_checker (
    input logic       clk,
    input logic       nRST,
    input logic [3:0] ColOut,
    input logic       arith_valid,
    input logic       result_valid
);

    timeunit 1ns;
    timeprecision 1ps;

    int err_cnt = 0;  // failed assertions so far

    // walking zero, never two columns at once
    a_one_col: assert property (@(posedge clk) disable iff (!nRST) $onehot(~ColOut))
        else begin
            $error("ColOut has not exactly one low bit: %b", ColOut);
            err_cnt++;
        end

    a_valid_pulse: assert property (@(posedge clk) disable iff (!nRST)
        result_valid |=> !result_valid)
        else begin
            $error("result_valid high for more than one cycle");
            err_cnt++;
        end

    // load cycle plus 16 shifts
    a_latency: assert property (@(posedge clk) disable iff (!nRST)
        result_valid |-> $past(arith_valid, 17))
        else begin
            $error("result_valid without arith_valid 17 cycles before");
            err_cnt++;
        end

    a_no_drop: assert property (@(posedge clk) disable iff (!nRST)
        $past(arith_valid, 17) |-> result_valid)
        else begin
            $error("arith_valid not followed by result_valid after 17 cycles");
            err_cnt++;
        end

endmodule

//--- test/tb_calc.sv
module tb_calc;

    timeunit 1ns;
    timeprecision 1ps;

    import calc_pkg::*;

    localparam int SEED        = 43;
    localparam int HOLD_CYCLES = 60;    // key down
    localparam int GAP_CYCLES  = 30;    // key up before the next press
    localparam int RESULT_WAIT = 2000;  // cycles allowed for a result
    localparam int NUM_SEQ     = 200;

    logic                      clk;
    logic                      nRST;
    logic [3:0]                RowIn;
    logic [3:0]                ColOut;
    logic                      result_valid;
    logic                      result_neg;
    logic [4*BCD_DIGITS-1:0]   result_bcd;
    logic                      result_ovf;

    logic                      key_down;   // keypad model
    logic [3:0]                key_idx;    // row*4 + col

    logic signed [DATA_W-1:0]  m_entry;    // reference model
    logic signed [DATA_W-1:0]  m_acc;
    op_t                       m_op;
    int                        m_cnt;      // digits in m_entry
    logic                      exp_neg;
    logic [4*BCD_DIGITS-1:0]   exp_bcd;
    logic                      exp_ovf;
    string                     test_name;

    calc_top i_calc_top (
        .clk, .nRST, .RowIn, .ColOut,
        .result_valid, .result_neg, .result_bcd, .result_ovf
    );

    bind calc_top calc_checker i_calc_checker (
        .clk, .nRST, .ColOut, .arith_valid, .result_valid
    );

    initial clk = 1'b0;
    always #5 clk = ~clk;

    // held key pulls its row low while its column is driven
    always_comb begin
        RowIn = 4'b1111;
        if (key_down && !ColOut[key_idx[1:0]]) RowIn[key_idx[3:2]] = 1'b0;
    end

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (expected !== actual) begin
            $display("error: %s expected %0h actual %0h", name, expected, actual);
            $display("TESTS FAILED");
            $fatal(1, "mismatch in %s", name);
        end
    endtask

    function automatic logic [3:0] digit_key(input int d);
        case (d)
            0:       return 4'd13;
            1, 2, 3: return 4'(d - 1);   // top row
            4, 5, 6: return 4'(d);
            default: return 4'(d + 1);   // 7 to 9
        endcase
    endfunction

    // digit value of a key or -1
    function automatic int key_digit(input logic [3:0] idx);
        if (idx == 4'd13) return 0;
        if (idx[1:0] == 2'd3 || idx[3:2] == 2'd3) return -1;  // letter column or bottom row
        return int'(idx[3:2]) * 3 + int'(idx[1:0]) + 1;
    endfunction

    function automatic logic [3:0] op_key(input int k);
        case (k)
            0:       return KEY_ADD;
            1:       return KEY_SUB;
            default: return KEY_MUL;
        endcase
    endfunction

    task automatic model_equal();
        int                       a;
        int                       b;
        int                       full;   // true result
        int                       mag;
        logic signed [DATA_W-1:0] res;
        a = int'(m_acc);
        b = int'(m_entry);
        case (m_op)
            OP_SUB:  full = a - b;
            OP_MUL:  full = a * b;
            default: full = a + b;
        endcase
        res     = DATA_W'(full);               // wraps
        exp_ovf = (full > 32767) || (full < -32768);
        exp_neg = (res < 0);
        mag     = exp_neg ? -int'(res) : int'(res);
        exp_bcd = '0;
        for (int i = 0; i < BCD_DIGITS; i++) begin
            exp_bcd[4*i +: 4] = 4'(mag % 10);  // lowest digit first
            mag = mag / 10;
        end
        m_acc   = res;                         // next calc chains on it
        m_entry = '0;
        m_cnt   = 0;
        m_op    = OP_ADD;
    endtask

    task automatic model_key(input logic [3:0] idx);
        int d;
        d = key_digit(idx);
        if (idx == KEY_NEG) begin
            m_entry = -m_entry;
        end else if (idx == KEY_ADD || idx == KEY_SUB || idx == KEY_MUL) begin
            if (m_cnt != 0) m_acc = m_entry;   // no digits keeps last result
            m_op    = (idx == KEY_ADD) ? OP_ADD : (idx == KEY_SUB) ? OP_SUB : OP_MUL;
            m_entry = '0;
            m_cnt   = 0;
        end else if (idx == KEY_EQUAL) begin
            model_equal();
        end else if (d >= 0 && m_cnt < MAX_ENTRY_DIGITS) begin
            m_entry = DATA_W'(m_entry * 10 + d);
            m_cnt++;
        end
        // '#' and a fifth digit leave the model alone
    endtask

    // idle cycles in which no result may show up
    task automatic quiet_cycles(input int n);
        for (int i = 0; i < n; i++) begin
            @(posedge clk);
            #1;
            check_value({test_name, " stray result"}, 32'd0, 32'(result_valid));
        end
    endtask

    task automatic press(input logic [3:0] idx);
        int waited;
        waited   = 0;
        key_idx  = idx;
        key_down = 1'b1;
        model_key(idx);
        if (idx == KEY_EQUAL) begin
            do begin
                if (waited >= RESULT_WAIT) begin
                    $display("no result came within %0d cycles of equal in %s",
                             RESULT_WAIT, test_name);
                    $display("TESTS FAILED");
                    $fatal(1, "result timeout");
                end
                @(posedge clk);
                #1;
                waited++;
            end while (!result_valid);
            check_value({test_name, " sign"}, 32'(exp_neg), 32'(result_neg));
            check_value({test_name, " bcd"}, 32'(exp_bcd), 32'(result_bcd));
            check_value({test_name, " overflow"}, 32'(exp_ovf), 32'(result_ovf));
            check_value({test_name, " assertions"}, 32'd0,
                        32'(i_calc_top.i_calc_checker.err_cnt));
        end
        if (waited < HOLD_CYCLES) quiet_cycles(HOLD_CYCLES - waited);
        key_down = 1'b0;
        quiet_cycles(GAP_CYCLES);
    endtask

    task automatic enter_number(input int n_digits);
        for (int i = 0; i < n_digits; i++) begin
            press(digit_key($urandom_range(0, 9)));
        end
    endtask

    task automatic random_sequence();
        if ($urandom_range(0, 3) != 0) begin        // else chain on last result
            enter_number($urandom_range(1, 5));
            if ($urandom_range(0, 3) == 0) press(KEY_NEG);
        end
        press(op_key($urandom_range(0, 2)));
        enter_number($urandom_range(1, 5));
        if ($urandom_range(0, 3) == 0) press(KEY_NEG);
        if ($urandom_range(0, 5) == 0) press(KEY_IGNORE);
        press(KEY_EQUAL);
    endtask

    initial begin
        void'($urandom(SEED));
        nRST      = 1'b0;
        key_down  = 1'b0;
        key_idx   = KEY_IGNORE;
        test_name = "reset";
        m_entry   = '0;
        m_acc     = '0;
        m_op      = OP_ADD;
        m_cnt     = 0;
        repeat (8) @(posedge clk);
        #1;
        check_value("reset ColOut", 32'hE, 32'(ColOut));
        nRST = 1'b1;
        quiet_cycles(5);

        test_name = "single";                   // accumulator still 0 here
        enter_number($urandom_range(1, 4));
        press(KEY_EQUAL);

        for (int k = 0; k < 3; k++) begin
            test_name = (k == 0) ? "add" : (k == 1) ? "sub" : "mul";
            repeat (4) begin
                enter_number((k == 2) ? 4 : $urandom_range(1, 4));  // big products overflow
                press(op_key(k));
                enter_number((k == 2) ? 4 : $urandom_range(1, 4));
                press(KEY_EQUAL);
            end
        end

        test_name = "neg";
        repeat (3) begin
            enter_number($urandom_range(1, 3));
            press(KEY_NEG);
            press(KEY_SUB);
            enter_number($urandom_range(1, 4));
            press(KEY_EQUAL);
        end

        test_name = "chain";
        enter_number(3);
        press(KEY_ADD);
        enter_number(2);
        press(KEY_EQUAL);
        press(op_key($urandom_range(0, 2)));     // no digits so the result is operand a
        enter_number(2);
        press(KEY_EQUAL);

        test_name = "limits";
        enter_number(5);
        press(KEY_IGNORE);
        press(KEY_ADD);
        enter_number(5);
        press(KEY_IGNORE);
        press(KEY_EQUAL);

        test_name = "random";
        repeat (NUM_SEQ) random_sequence();

        if (i_calc_top.i_calc_checker.err_cnt == 0) begin
            $display("TESTS PASSED");
            $finish;
        end else begin
            $display("TESTS FAILED");
            $fatal(1, "%0d assertion failures", i_calc_top.i_calc_checker.err_cnt);
        end
    end

endmodule

//--- compile.f
hw/calc_pkg.sv
hw/keypad_scanner.sv
hw/calc_controller.sv
hw/arith_unit.sv
hw/bin_to_bcd.sv
hw/calc_top.sv
test/calc_checker.sv
test/tb_calc.sv

//--- Makefile
# Verilator flow for the keypad calculator

LOG = sim.log

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert --timescale 1ns/1ps \
		-f compile.f --top-module tb_calc -Mdir obj_dir -o Vtb_calc

run: compile
	./obj_dir/Vtb_calc | tee $(LOG)
	grep -q "^TESTS PASSED$$" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
